// ==== hw/fpAddSub_macros.svh ====
`ifndef FP_ADD_SUB_MACROS_SVH
`define FP_ADD_SUB_MACROS_SVH

// Half precision layout {sign, exponent, fraction}
`define FP_WIDTH 16
`define FP_EXP_W 5           // Biased exponent, bias 15
`define FP_MAN_W 10          // Stored fraction, hidden one not included

// Working significand {hidden, fraction, guard, round, sticky}
`define FP_GRS_W 3
`define FP_SIG_W (1 + `FP_MAN_W + `FP_GRS_W)

// Special encodings
`define FP_EXP_MAX {`FP_EXP_W{1'b1}}                                   // Inf and NaN exponent
`define FP_QNAN {1'b0, `FP_EXP_MAX, 1'b1, {(`FP_MAN_W - 1){1'b0}}}    // 16'h7E00

// Flags {overflow, underflow, invalid, inexact}
`define FP_FLAG_W 4

`endif

// ==== hw/fpAddSubPkg.sv ====
`include "fpAddSub_macros.svh"

package fpAddSubPkg;

	// One encoded half precision value
	typedef logic [`FP_WIDTH-1:0] halfT;

	// Exponent fields
	typedef logic [`FP_EXP_W-1:0] expT;      // Biased
	typedef logic [`FP_EXP_W:0] wideExpT;    // Extra MSB catches carry or borrow

	// Fraction without the hidden one
	typedef logic [`FP_MAN_W-1:0] fracT;

	// Significand with hidden one and GRS bits
	typedef logic [`FP_SIG_W-1:0] sigT;
	typedef logic [`FP_SIG_W:0] sumT;        // One more for the add carry

	// Shift count, covers 0 up to FP_SIG_W
	typedef logic [$clog2(`FP_SIG_W + 1)-1:0] shiftT;

	// High to low {overflow, underflow, invalid, inexact}
	typedef logic [`FP_FLAG_W-1:0] flagsT;

endpackage

// ==== hw/fpClassify.sv ====
`timescale 1ns/1ps
`include "fpAddSub_macros.svh"

module fpClassify (
	input fpAddSubPkg::halfT in,
	output logic sign,
	output fpAddSubPkg::expT exp,
	output fpAddSubPkg::fracT frac,
	output logic isNaN,
	output logic isInf,
	output logic isZero
);

	logic expAllOnes;
	logic fracZero;

	// Field split
	assign sign = in[`FP_WIDTH-1];
	assign exp = in[`FP_WIDTH-2:`FP_MAN_W];
	assign frac = in[`FP_MAN_W-1:0];

	assign expAllOnes = (exp == `FP_EXP_MAX);
	assign fracZero = ~|frac;

	// Top exponent code splits into NaN and infinity on the fraction
	assign isNaN = expAllOnes & ~fracZero;
	assign isInf = expAllOnes & fracZero;

	// Exponent zero reads as zero
	// Subnormal fraction is ignored, so denormals flush here
	assign isZero = ~|exp;

endmodule

// ==== hw/fpAlign.sv ====
`timescale 1ns/1ps
`include "fpAddSub_macros.svh"

module fpAlign (
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic sub,                   // 1 flips the sign of B
	input logic signA,
	input logic signB,
	input fpAddSubPkg::expT expA,
	input fpAddSubPkg::expT expB,
	input fpAddSubPkg::fracT fracA,
	input fpAddSubPkg::fracT fracB,
	input logic isNaNA,
	input logic isNaNB,
	input logic isInfA,
	input logic isInfB,
	input logic isZeroA,
	input logic isZeroB,
	output logic valid1,
	output fpAddSubPkg::sigT sigMax,
	output fpAddSubPkg::sigT sigMin,
	output fpAddSubPkg::expT expMax,
	output logic signMax,
	output logic effSignMin,
	output logic specNaN,
	output logic specInf,
	output logic specInfSign
);
	import fpAddSubPkg::*;

	logic effSignB;
	logic aLarger;
	fracT fracAz;
	fracT fracBz;
	sigT sigA;
	sigT sigB;
	sigT sigBig;
	sigT sigSmall;
	expT expBig;
	expT expSmall;
	expT expDiff;
	shiftT shiftAmt;
	sigT shifted;
	sigT lostMask;
	sigT sigAligned;
	logic sticky;
	logic infClash;

	assign effSignB = signB ^ sub;

	// Zero operands lose their fraction so a denormal compares equal to zero
	assign fracAz = isZeroA ? '0 : fracA;
	assign fracBz = isZeroB ? '0 : fracB;

	// Hidden one only for nonzero operands, GRS start empty
	assign sigA = {~isZeroA, fracAz, {`FP_GRS_W{1'b0}}};
	assign sigB = {~isZeroB, fracBz, {`FP_GRS_W{1'b0}}};

	// Magnitude compare, exponent first then fraction
	assign aLarger = {expA, fracAz} >= {expB, fracBz};

	assign sigBig = aLarger ? sigA : sigB;
	assign sigSmall = aLarger ? sigB : sigA;
	assign expBig = aLarger ? expA : expB;
	assign expSmall = aLarger ? expB : expA;
	assign expDiff = expBig - expSmall;     // Never negative after the swap
	assign shiftAmt = shiftT'(expDiff);     // Only used below FP_SIG_W

	// Right shift, collect everything that falls off
	assign shifted = sigSmall >> shiftAmt;
	assign lostMask = ~({`FP_SIG_W{1'b1}} << shiftAmt);
	assign sticky = |(sigSmall & lostMask);

	// Far apart exponents leave only sticky
	assign sigAligned = (expDiff >= `FP_SIG_W) ?
		{{(`FP_SIG_W - 1){1'b0}}, |sigSmall} :
		{shifted[`FP_SIG_W-1:1], shifted[0] | sticky};

	// Inf minus inf is invalid
	assign infClash = isInfA & isInfB & (signA ^ effSignB);

	always_ff @(posedge clk) begin
		if (rst) begin
			valid1 <= 1'b0;
		end else begin
			valid1 <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			sigMax <= sigBig;
			sigMin <= sigAligned;
			expMax <= expBig;                        // Common exponent
			signMax <= aLarger ? signA : effSignB;
			effSignMin <= aLarger ? effSignB : signA;
			specNaN <= isNaNA | isNaNB | infClash;
			specInf <= (isInfA | isInfB) & ~(isNaNA | isNaNB | infClash);
			specInfSign <= isInfA ? signA : effSignB;  // Both inf here means same sign
		end
	end

endmodule

// ==== hw/fpMantissaAdd.sv ====
`timescale 1ns/1ps

module fpMantissaAdd (
	input logic clk,
	input logic rst,
	input logic valid1,
	input fpAddSubPkg::sigT sigMax,
	input fpAddSubPkg::sigT sigMin,
	input fpAddSubPkg::expT expMax,
	input logic signMax,
	input logic effSignMin,
	input logic specNaN,
	input logic specInf,
	input logic specInfSign,
	output logic valid2,
	output fpAddSubPkg::sumT sum,
	output fpAddSubPkg::expT expMax2,
	output logic resSign,
	output logic subtracted,
	output logic specNaN2,
	output logic specInf2,
	output logic specInfSign2
);
	import fpAddSubPkg::*;

	logic doSub;
	sumT nextSum;

	// Sign mismatch means effective subtract
	assign doSub = signMax ^ effSignMin;

	// Larger operand first, so the difference stays non-negative
	assign nextSum = doSub ?
		({1'b0, sigMax} - {1'b0, sigMin}) :
		({1'b0, sigMax} + {1'b0, sigMin});   // MSB is the carry out

	always_ff @(posedge clk) begin
		if (rst) begin
			valid2 <= 1'b0;
		end else begin
			valid2 <= valid1;
		end
	end

	always_ff @(posedge clk) begin
		if (valid1) begin
			sum <= nextSum;
			expMax2 <= expMax;
			resSign <= signMax;       // Larger magnitude decides the sign
			subtracted <= doSub;      // Needed later for the sign of an exact zero
			specNaN2 <= specNaN;
			specInf2 <= specInf;
			specInfSign2 <= specInfSign;
		end
	end

endmodule

// ==== hw/fpNormalize.sv ====
`timescale 1ns/1ps
`include "fpAddSub_macros.svh"

module fpNormalize (
	input logic clk,
	input logic rst,
	input logic valid2,
	input fpAddSubPkg::sumT sum,
	input fpAddSubPkg::expT expMax2,
	input logic resSign,
	input logic subtracted,
	input logic specNaN2,
	input logic specInf2,
	input logic specInfSign2,
	output logic valid3,
	output fpAddSubPkg::sigT normSig,
	output fpAddSubPkg::wideExpT normExp,
	output logic zeroSum,
	output logic tiny,
	output logic resSign3,
	output logic specNaN3,
	output logic specInf3,
	output logic specInfSign3
);
	import fpAddSubPkg::*;

	logic carry;
	logic sumZero;
	shiftT lzc;
	sigT shiftedSig;
	sigT nextSig;
	wideExpT nextExp;
	logic nextTiny;

	assign carry = sum[`FP_SIG_W];
	assign sumZero = ~|sum;

	// Leading zero count below the carry bit, highest set bit wins
	always_comb begin
		lzc = shiftT'(`FP_SIG_W);    // All zero
		for (int i = 0; i < `FP_SIG_W; i++) begin
			if (sum[i]) begin
				lzc = shiftT'(`FP_SIG_W - 1 - i);
			end
		end
	end

	assign shiftedSig = sum[`FP_SIG_W-1:0] << lzc;

	// Carry case shifts right once and folds the lost bit into sticky
	assign nextSig = carry ? {sum[`FP_SIG_W:2], sum[1] | sum[0]} : shiftedSig;
	assign nextExp = carry ?
		wideExpT'(expMax2) + wideExpT'(1) :
		wideExpT'(expMax2) - wideExpT'(lzc);

	// Exponent would drop under one, flush later
	assign nextTiny = ~carry & ~sumZero & (wideExpT'(expMax2) <= wideExpT'(lzc));

	always_ff @(posedge clk) begin
		if (rst) begin
			valid3 <= 1'b0;
		end else begin
			valid3 <= valid2;
		end
	end

	always_ff @(posedge clk) begin
		if (valid2) begin
			normSig <= nextSig;
			normExp <= nextExp;
			zeroSum <= sumZero;
			tiny <= nextTiny;
			// Exact cancellation gives +0
			// Same-sign zeros keep their common sign
			resSign3 <= (sumZero & subtracted) ? 1'b0 : resSign;
			specNaN3 <= specNaN2;
			specInf3 <= specInf2;
			specInfSign3 <= specInfSign2;
		end
	end

endmodule

// ==== hw/fpRoundPack.sv ====
`timescale 1ns/1ps
`include "fpAddSub_macros.svh"

module fpRoundPack (
	input logic clk,
	input logic rst,
	input logic valid3,
	input fpAddSubPkg::sigT normSig,
	input fpAddSubPkg::wideExpT normExp,
	input logic zeroSum,
	input logic tiny,
	input logic resSign,
	input logic specNaN,
	input logic specInf,
	input logic specInfSign,
	output logic outValid,
	output fpAddSubPkg::halfT result,
	output fpAddSubPkg::flagsT flags
);
	import fpAddSubPkg::*;

	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic lostBits;
	logic roundUp;
	logic roundCarry;
	logic [`FP_MAN_W+1:0] roundedSig;    // Hidden one plus fraction plus carry
	wideExpT finalExp;
	expT expField;
	logic overflow;
	logic setOvf;
	logic setUnf;
	logic setInv;
	logic setInx;
	halfT nextResult;
	flagsT nextFlags;

	// GRS sit in the low bits of the normalized significand
	assign guardBit = normSig[`FP_GRS_W-1];
	assign roundBit = normSig[`FP_GRS_W-2];
	assign stickyBit = normSig[0];
	assign lostBits = guardBit | roundBit | stickyBit;

	// Nearest even
	// Round up above half, or at exactly half with an odd LSB
	assign roundUp = guardBit & (roundBit | stickyBit | normSig[`FP_GRS_W]);
	assign roundedSig = {1'b0, normSig[`FP_SIG_W-1:`FP_GRS_W]} +
		{{(`FP_MAN_W + 1){1'b0}}, roundUp};
	assign roundCarry = roundedSig[`FP_MAN_W+1];    // 1.11..1 rolled over to 10.0

	assign finalExp = normExp + wideExpT'(roundCarry);
	assign expField = zeroSum ? '0 : finalExp[`FP_EXP_W-1:0];

	// Tiny and zero carry a wrapped exponent, keep them out of the compare
	assign overflow = ~zeroSum & ~tiny & (finalExp >= {1'b0, `FP_EXP_MAX});

	// Result select in priority order
	always_comb begin
		setOvf = 1'b0;
		setUnf = 1'b0;
		setInv = 1'b0;
		setInx = 1'b0;
		if (specNaN) begin
			nextResult = `FP_QNAN;
			setInv = 1'b1;
		end else if (specInf) begin
			nextResult = {specInfSign, `FP_EXP_MAX, {`FP_MAN_W{1'b0}}};  // Exact
		end else if (overflow) begin
			nextResult = {resSign, `FP_EXP_MAX, {`FP_MAN_W{1'b0}}};
			setOvf = 1'b1;
			setInx = 1'b1;
		end else if (tiny) begin
			nextResult = {resSign, {(`FP_WIDTH - 1){1'b0}}};    // Flush to signed zero
			setUnf = 1'b1;
			setInx = 1'b1;
		end else begin
			nextResult = {resSign, expField, roundedSig[`FP_MAN_W-1:0]};
			setInx = lostBits;
		end
	end

	assign nextFlags = {setOvf, setUnf, setInv, setInx};

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else begin
			outValid <= valid3;
		end
	end

	// Output bank, held between results
	always_ff @(posedge clk) begin
		if (valid3) begin
			result <= nextResult;
			flags <= nextFlags;
		end
	end

endmodule

// ==== hw/fpAddSub.sv ====
`timescale 1ns/1ps

module fpAddSub (
	input logic clk,
	input logic rst,
	input logic inValid,
	input fpAddSubPkg::halfT a,
	input fpAddSubPkg::halfT b,
	input logic sub,                      // 0 add, 1 subtract
	output logic outValid,
	output fpAddSubPkg::halfT result,
	output fpAddSubPkg::flagsT flags
);
	import fpAddSubPkg::*;

	// Decoded operands
	logic signA, signB;
	expT expA, expB;
	fracT fracA, fracB;
	logic isNaNA, isNaNB, isInfA, isInfB, isZeroA, isZeroB;

	// Align to add
	logic valid1, signMax, effSignMin, specNaN, specInf, specInfSign;
	sigT sigMax, sigMin;
	expT expMax;

	// Add to normalize
	logic valid2, resSign, subtracted, specNaN2, specInf2, specInfSign2;
	sumT sum;
	expT expMax2;

	// Normalize to round
	logic valid3, zeroSum, tiny, resSign3, specNaN3, specInf3, specInfSign3;
	sigT normSig;
	wideExpT normExp;

	fpClassify classifyA (.in(a), .sign(signA), .exp(expA), .frac(fracA),
		.isNaN(isNaNA), .isInf(isInfA), .isZero(isZeroA));
	fpClassify classifyB (.in(b), .sign(signB), .exp(expB), .frac(fracB),
		.isNaN(isNaNB), .isInf(isInfB), .isZero(isZeroB));

	// Swap and align
	fpAlign alignStage (.clk, .rst, .inValid, .sub, .signA, .signB, .expA, .expB,
		.fracA, .fracB, .isNaNA, .isNaNB, .isInfA, .isInfB, .isZeroA, .isZeroB,
		.valid1, .sigMax, .sigMin, .expMax, .signMax, .effSignMin,
		.specNaN, .specInf, .specInfSign);

	// Significand add or subtract
	fpMantissaAdd addStage (.clk, .rst, .valid1, .sigMax, .sigMin, .expMax, .signMax,
		.effSignMin, .specNaN, .specInf, .specInfSign, .valid2, .sum, .expMax2,
		.resSign, .subtracted, .specNaN2, .specInf2, .specInfSign2);

	// Leading zero normalize
	fpNormalize normStage (.clk, .rst, .valid2, .sum, .expMax2, .resSign, .subtracted,
		.specNaN2, .specInf2, .specInfSign2, .valid3, .normSig, .normExp, .zeroSum,
		.tiny, .resSign3, .specNaN3, .specInf3, .specInfSign3);

	// Round, specials and flags
	fpRoundPack roundStage (.clk, .rst, .valid3, .normSig, .normExp, .zeroSum, .tiny,
		.resSign(resSign3), .specNaN(specNaN3), .specInf(specInf3),
		.specInfSign(specInfSign3), .outValid, .result, .flags);

endmodule

// ==== tb/fpAddSubTb.sv ====
`timescale 1ns/1ps
`include "fpAddSub_macros.svh"

module fpAddSubTb;
	import fpAddSubPkg::*;

	localparam int maxVectors = 64;
	localparam int pipeDepth = 4;          // Register banks between a and result

	// One operation in flight
	typedef struct packed {
		int idx;
		int issue;                         // Cycle of the driving falling edge
		halfT res;
		flagsT flg;
	} pendingT;

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	halfT a;
	halfT b;
	logic sub;
	logic outValid;
	halfT result;
	flagsT flags;

	// Golden table
	logic [8*64-1:0] names [maxVectors];
	logic subVec [maxVectors];
	halfT aVec [maxVectors];
	halfT bVec [maxVectors];
	halfT resVec [maxVectors];
	flagsT flagVec [maxVectors];
	int vecCount;

	pendingT pending [$];                  // Expected results in issue order
	int cycleCount = 0;
	int cycleLimit = 20;

	fpAddSub fpAddSub_inst (.clk, .rst, .inValid, .a, .b, .sub, .outValid, .result, .flags);

	always #2 clk = ~clk;                  // 4 ns period

	task automatic failRun(input string why);
		$display("%0s", why);
		$display("Test failed");
		$fatal(1, "%0s", why);
	endtask

	// Lines that do not hold six fields are comments
	task automatic loadGolden();
		int fd;
		int code;
		logic [8*64-1:0] textLine;
		logic [8*64-1:0] nameBuf;
		logic s;
		halfT va;
		halfT vb;
		halfT vr;
		flagsT vf;
		fd = $fopen("tb/fpAddSub_golden.txt", "r");
		assert (fd != 0) else failRun("cannot open the golden vector file");
		vecCount = 0;
		textLine = '0;
		while ($fgets(textLine, fd) != 0) begin
			code = $sscanf(textLine, "%s %h %h %h %h %h", nameBuf, s, va, vb, vr, vf);
			if (code == 6) begin
				assert (vecCount < maxVectors) else failRun("too many vectors in the golden file");
				names[vecCount] = nameBuf;
				subVec[vecCount] = s;
				aVec[vecCount] = va;
				bVec[vecCount] = vb;
				resVec[vecCount] = vr;
				flagVec[vecCount] = vf;
				vecCount++;
			end
			textLine = '0;                 // Old text must not leak into a shorter line
		end
		$fclose(fd);
		assert (vecCount > 0) else failRun("the golden file holds no vectors");
	endtask

	task automatic issueVector(input int i);
		pendingT entry;
		inValid = 1'b1;
		sub = subVec[i];
		a = aVec[i];
		b = bVec[i];
		entry.idx = i;
		entry.issue = cycleCount;
		entry.res = resVec[i];
		entry.flg = flagVec[i];
		pending.push_back(entry);
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycleCount++;
		assert (cycleCount < cycleLimit) else
			failRun($sformatf("timeout, run still busy after %0d cycles", cycleCount));
	end

	// Output side sampled mid cycle
	always @(negedge clk) begin
		pendingT head;
		if (rst !== 1'b0) begin
			assert (outValid === 1'b0) else failRun("outValid not low while in reset");
		end else if (outValid) begin
			assert (pending.size() != 0) else failRun("outValid high with nothing in flight");
			head = pending.pop_front();
			assert (cycleCount - head.issue == pipeDepth) else
				failRun($sformatf("%0s came out after %0d cycles instead of %0d",
					names[head.idx], cycleCount - head.issue, pipeDepth));
			assert (result === head.res) else
				failRun($sformatf("Mismatch %0s result expected %h actual %h",
					names[head.idx], head.res, result));
			assert (flags === head.flg) else
				failRun($sformatf("Mismatch %0s flags expected %b actual %b",
					names[head.idx], head.flg, flags));
		end else if (pending.size() != 0) begin
			// Oldest operation overdue
			assert (cycleCount - pending[0].issue < pipeDepth) else
				failRun($sformatf("%0s gave no result %0d cycles after issue",
					names[pending[0].idx], pipeDepth));
		end
	end

	initial begin
		int gap;
		rst = 1'b1;
		inValid = 1'b1;                    // Strobe held high in reset so the pipe must drop it
		a = '0;
		b = '0;
		sub = 1'b0;
		void'($urandom(19));
		loadGolden();
		cycleLimit = 3 * vecCount + 20;    // Worst case 3 cycles per vector plus drain
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		inValid = 1'b0;
		for (int i = 0; i < vecCount; i++) begin
			// Groups of four back to back and others spaced 0 to 2 idle cycles
			gap = ((i % 8) < 4) ? 0 : int'($urandom % 3);
			repeat (gap) begin
				@(negedge clk);
				inValid = 1'b0;
			end
			@(negedge clk);
			issueVector(i);
		end
		@(negedge clk);
		inValid = 1'b0;
		while (pending.size() != 0) @(negedge clk);
		repeat (2) @(negedge clk);         // Room for a stray outValid
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== tb/fpAddSub_golden.txt ====
# Name, then sub, a, b, expected result and expected flags, all but the name in hex
# Order of flag bits, high to low: overflow, underflow, invalid, inexact
addOnes      0 3C00 3C00 4000 0
addOneTwo    0 3C00 4000 4200 0
subToNeg     1 3C00 4000 BC00 0
carryFrac    0 4500 4300 4840 0
cancelTen    1 3C01 3C00 1400 0
cancelEight  0 4801 C800 2000 0
zeroExact    1 3C00 3C00 0000 0
zeroNegNeg   0 8000 8000 8000 0
zeroMixed    0 BC00 3C00 0000 0
tieDown      0 3C00 1000 3C00 1
tieUp        0 3C01 1000 3C02 1
aboveHalf    0 3C00 1200 3C01 1
belowHalf    0 3C00 0C00 3C00 1
roundCarry   0 3FFF 1000 4000 1
tieSub       1 3C01 1000 3C00 1
stickyOnly   0 3C00 0400 3C00 1
stickyFar    0 5000 0400 5000 1
stickyBorrow 1 3C00 0400 3C00 1
nanLow       0 7C01 3C00 7E00 2
nanNeg       1 3C00 FE00 7E00 2
infClash     1 7C00 7C00 7E00 2
infPlusOne   0 7C00 3C00 7C00 0
oneMinusInf  1 3C00 7C00 FC00 0
ovfSum       0 7BFF 7BFF 7C00 9
ovfRound     0 7BFF 4C00 7C00 9
nearMax      0 7BFF 4800 7BFF 1
unfPos       1 0401 0400 0000 5
unfNeg       1 8401 8400 8000 5
subnormAdd   0 0200 3C00 3C00 0
subnormNeg   1 8300 0000 8000 0

// ==== sim.f ====
+incdir+hw
hw/fpAddSubPkg.sv
hw/fpClassify.sv
hw/fpAlign.sv
hw/fpMantissaAdd.sv
hw/fpNormalize.sv
hw/fpRoundPack.sv
hw/fpAddSub.sv
tb/fpAddSubTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -f sim.f --top-module fpAddSubTb -o fpAddSubSim &&
	./obj_dir/fpAddSubSim || exit 1
